// ==== list.f ====
vc_cfg_pkg.sv
vc_types_pkg.sv
vc_ctrl_if.sv
victim_cache_control.sv
victim_cache_datapath.sv
victim_cache.sv
tb_victim_cache.sv

// ==== Makefile ====
TOP := tb_victim_cache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall -f list.f --top-module victim_cache

clean:
	rm -rf obj_dir sim.log

// ==== tb_victim_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_victim_cache;

	localparam int aw          = vc_cfg_pkg::ADDR_W; // Line address width.
	localparam int lw          = vc_cfg_pkg::LINE_W; // Line width.
	localparam int num_txn     = 600;                // Random transactions.
	localparam int txn_timeout = 40;                 // Cycles per request.

	typedef logic [aw-1:0] addr_t;
	typedef logic [lw-1:0] line_t;

	logic  clk;
	logic  arst_n;
	logic  mem_read;
	logic  d_v_mem_swap;
	addr_t mem_address;
	addr_t evict_address;
	line_t evict_data;
	logic  evict_dirty;
	line_t mem_rdata;
	logic  mem_resp;
	logic  pmem_read;
	logic  pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic  pmem_resp;

	line_t                   mem_model [addr_t]; // Physical memory.
	vc_types_pkg::vc_entry_t vic;                // Expected victim entry.

	int  value_errors = 0; // Wrong values.
	int  other_errors = 0; // Protocol and ordering faults.
	int  timeouts     = 0;
	bit  timed_out    = 0;

	victim_cache #(
		.addr_w (aw),
		.line_w (lw)
	) UUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.mem_read      (mem_read),
		.d_v_mem_swap  (d_v_mem_swap),
		.mem_address   (mem_address),
		.evict_address (evict_address),
		.evict_data    (evict_data),
		.evict_dirty   (evict_dirty),
		.mem_rdata     (mem_rdata),
		.mem_resp      (mem_resp),
		.pmem_read     (pmem_read),
		.pmem_write    (pmem_write),
		.pmem_address  (pmem_address),
		.pmem_wdata    (pmem_wdata),
		.pmem_rdata    (pmem_rdata),
		.pmem_resp     (pmem_resp)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	function automatic line_t rand_line();
		line_t r;
		for (int i = 0; i < lw / 32; i++)
			r[32*i +: 32] = $urandom;
		return r;
	endfunction

	// Lines never written hold random data.
	function automatic line_t read_line(input addr_t a);
		if (!mem_model.exists(a))
			mem_model[a] = rand_line();
		return mem_model[a];
	endfunction

	// Small pool of lines, so the victim hits often.
	function automatic addr_t addr_of(input int idx);
		return addr_t'(32'h15a0 + idx);
	endfunction

	task automatic check_line(input string name, input line_t got, input line_t exp);
		assert (got === exp)
		else
		begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		assert (got === exp)
		else
		begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			value_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("Error at %0t: %s", $time, what);
			other_errors++;
		end
	endtask

	// Quiet bus between requests.
	task automatic check_idle();
		check_true(!pmem_read && !pmem_write, "memory access while no request is pending");
		check_true(!mem_resp, "mem_resp while no request is pending");
	endtask

	// One L1 request, with the memory responder run in the same cycle loop.
	task automatic run_txn(input bit is_swap, input addr_t addr, input addr_t ev_addr,
		input line_t ev_data, input bit ev_dirty);
		vc_types_pkg::vc_entry_t old_vic;
		bit    hit;
		bit    exp_wb;
		bit    done;
		bit    seen_read;
		bit    seen_write;
		bit    busy;
		bit    give_resp;
		bit    resp_is_read;
		addr_t resp_addr;
		int    cyc;
		int    wait_left;
		int    first_acc;

		old_vic    = vic;
		hit        = vic.valid && (vic.tag == addr);
		exp_wb     = is_swap && !hit && vic.valid && vic.dirty; // Dirty victim goes out.
		done       = 0;
		seen_read  = 0;
		seen_write = 0;
		busy       = 0;
		wait_left  = 0;
		first_acc  = -1;
		cyc        = 0;

		mem_read      = !is_swap;
		d_v_mem_swap  = is_swap;
		mem_address   = addr;
		evict_address = ev_addr;
		evict_data    = ev_data;
		evict_dirty   = ev_dirty;

		while (!done && cyc < txn_timeout)
		begin
			@(negedge clk); // Outputs settled here.
			give_resp = 0;
			check_true(!(pmem_read && pmem_write), "pmem_read and pmem_write high together");
			if ((pmem_read || pmem_write) && first_acc < 0)
				first_acc = cyc;
			if (pmem_write)
			begin
				seen_write = 1;
				check_true(exp_wb, "write-back without a dirty victim on a swap miss");
				check_addr("pmem_address", pmem_address, old_vic.tag);
				check_line("pmem_wdata", pmem_wdata, old_vic.data);
				if (pmem_resp)
					mem_model[pmem_address] = pmem_wdata; // Memory takes the line.
			end
			if (pmem_read)
			begin
				seen_read = 1;
				check_true(!exp_wb || seen_write, "line fetch before the write-back");
				check_addr("pmem_address", pmem_address, addr);
				check_true(mem_resp === pmem_resp, "mem_resp does not follow pmem_resp");
			end
			if (mem_resp)
			begin
				done = 1;
				if (hit)
				begin
					check_true(cyc == 0, "hit answered later than the first cycle");
					check_line("mem_rdata", mem_rdata, old_vic.data);
				end
				else
				begin
					check_true(pmem_read, "miss answered without a memory read");
					check_line("mem_rdata", mem_rdata, read_line(addr));
				end
			end

			// Memory answers 0 to 5 cycles after it sees a command.
			if ((pmem_read || pmem_write) && !pmem_resp)
			begin
				if (!busy)
				begin
					busy      = 1;
					wait_left = $urandom_range(0, 5);
				end
				if (wait_left == 0)
					give_resp = 1;
				else
					wait_left--;
			end
			if (pmem_resp)
				busy = 0; // Access ended this cycle.
			resp_addr    = pmem_address;
			resp_is_read = pmem_read;

			@(posedge clk);
			#1;
			pmem_resp = give_resp;
			if (give_resp && resp_is_read)
				pmem_rdata = read_line(resp_addr);
			else
				pmem_rdata = rand_line(); // Junk outside a response.
			cyc++;
		end

		mem_read     = 1'b0;
		d_v_mem_swap = 1'b0;

		if (!done)
		begin
			$display("Timeout: no mem_resp within %0d cycles, controller in %s",
				txn_timeout, UUT.u_control.state.name());
			timeouts++;
			timed_out = 1;
		end
		else
		begin
			check_true(hit || first_acc == 1, "miss did not reach memory one cycle in");
			check_true(hit || seen_read, "miss without a line fetch");
			check_true(seen_write == exp_wb, "write-back missing or unexpected");
			check_true(!hit || first_acc < 0, "memory accessed on a victim hit");
			if (is_swap)
			begin
				// Evicted line always lands in the entry.
				vic.valid = 1'b1;
				vic.dirty = ev_dirty;
				vic.tag   = ev_addr;
				vic.data  = ev_data;
			end
		end
	endtask

	initial
	begin
		int idx;
		int ev_idx;
		int gap;
		bit is_swap;
		bit ev_dirty;

		void'($urandom(11378));
		arst_n        = 1'b0;
		mem_read      = 1'b0;
		d_v_mem_swap  = 1'b0;
		mem_address   = '0;
		evict_address = '0;
		evict_data    = '0;
		evict_dirty   = 1'b0;
		pmem_rdata    = '0;
		pmem_resp     = 1'b0;
		vic           = '0; // Entry starts invalid.

		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_idle();
		@(posedge clk);
		#1;

		// Empty victim, so the first read must go to memory.
		run_txn(1'b0, addr_of(0), addr_of(1), rand_line(), 1'b0);

		for (int n = 0; n < num_txn && !timed_out; n++)
		begin
			idx      = $urandom_range(0, 15);
			ev_idx   = (idx + 1 + $urandom_range(0, 14)) % 16; // Never the requested line.
			is_swap  = ($urandom_range(0, 1) == 1);
			ev_dirty = ($urandom_range(0, 1) == 1);
			gap      = $urandom_range(0, 2);
			for (int g = 0; g < gap; g++)
			begin
				@(negedge clk);
				check_idle();
				@(posedge clk);
				#1;
			end
			run_txn(is_swap, addr_of(idx), addr_of(ev_idx), rand_line(), ev_dirty);
		end

		$display("Errors: %0d value, %0d protocol, %0d timeouts",
			value_errors, other_errors, timeouts);
		if (value_errors == 0 && other_errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : tb_victim_cache

`default_nettype wire

// ==== victim_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-entry victim cache between an L1 data cache and memory.
module victim_cache #(
	parameter int addr_w = vc_cfg_pkg::ADDR_W, // Line address width.
	parameter int line_w = vc_cfg_pkg::LINE_W  // Line data width.
) (
	input  logic              clk,           // Core clock.
	input  logic              arst_n,        // Async reset, active low.

	input  logic              mem_read,      // L1 read, no eviction.
	input  logic              d_v_mem_swap,  // L1 read with eviction.
	input  logic [addr_w-1:0] mem_address,   // Requested line.
	input  logic [addr_w-1:0] evict_address, // Evicted line address.
	input  logic [line_w-1:0] evict_data,    // Evicted line payload.
	input  logic              evict_dirty,   // Evicted line dirty.
	output logic [line_w-1:0] mem_rdata,     // Line to L1.
	output logic              mem_resp,      // Request done.

	output logic              pmem_read,     // Memory read.
	output logic              pmem_write,    // Memory write.
	output logic [addr_w-1:0] pmem_address,  // Memory line address.
	output logic [line_w-1:0] pmem_wdata,    // Memory write data.
	input  logic [line_w-1:0] pmem_rdata,    // Memory read data.
	input  logic              pmem_resp      // Memory done.
);

	// FSM to datapath link.
	vc_ctrl_if #(
		.addr_w (addr_w),
		.line_w (line_w)
	) cif ();

	victim_cache_control u_control
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.mem_read     (mem_read),
		.d_v_mem_swap (d_v_mem_swap),
		.pmem_resp    (pmem_resp),
		.mem_resp     (mem_resp),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.cif          (cif.ctrl)
	);

	victim_cache_datapath #(
		.addr_w (addr_w),
		.line_w (line_w)
	) u_datapath (
		.clk           (clk),
		.arst_n        (arst_n),
		.mem_address   (mem_address),
		.evict_address (evict_address),
		.evict_data    (evict_data),
		.evict_dirty   (evict_dirty),
		.pmem_rdata    (pmem_rdata),
		.mem_rdata     (mem_rdata),
		.pmem_address  (pmem_address),
		.pmem_wdata    (pmem_wdata),
		.cif           (cif.dpath)
	);

endmodule : victim_cache

`default_nettype wire

// ==== victim_cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

// Victim entry storage, tag compare and data steering.
module victim_cache_datapath #(
	parameter int addr_w = vc_cfg_pkg::ADDR_W, // Line address width.
	parameter int line_w = vc_cfg_pkg::LINE_W  // Line data width.
) (
	input  logic              clk,           // Core clock.
	input  logic              arst_n,        // Async reset, active low.
	input  logic [addr_w-1:0] mem_address,   // Requested line.
	input  logic [addr_w-1:0] evict_address, // Line leaving L1.
	input  logic [line_w-1:0] evict_data,    // Its payload.
	input  logic              evict_dirty,   // Its dirty bit.
	input  logic [line_w-1:0] pmem_rdata,    // Line from memory.
	output logic [line_w-1:0] mem_rdata,     // Line to L1.
	output logic [addr_w-1:0] pmem_address,  // Memory line address.
	output logic [line_w-1:0] pmem_wdata,    // Write-back payload.
	vc_ctrl_if.dpath          cif            // FSM commands and status.
);

	vc_types_pkg::vc_entry_t entry;   // The stored victim line.
	vc_types_pkg::vc_entry_t entry_d; // Line offered for loading.

	// Evicted line as it will be stored.
	always_comb
	begin
		entry_d.valid = 1'b1;          // Any load fills the entry.
		entry_d.dirty = evict_dirty;
		entry_d.tag   = evict_address;
		entry_d.data  = evict_data;
	end

	// Entry register. Only the flags clear on reset.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			entry.valid <= 1'b0;
			entry.dirty <= 1'b0;
		end
		else if (cif.ld_cache)
		begin
			entry <= entry_d; // Swap or fill.
		end
	end

	// Status back to the FSM.
	always_comb
	begin
		cif.tag_match = (entry.tag == mem_address); // Full-address compare.
		cif.valid     = entry.valid;
		cif.dirty     = entry.dirty;
	end

	// Line to L1, from the entry on a hit, else from memory.
	always_comb
	begin
		if (cif.ld_from_vic)
			mem_rdata = entry.data;
		else
			mem_rdata = pmem_rdata; // Fetch passes through.
	end

	// Memory address, requested line on a fetch, victim on a write-back.
	always_comb
	begin
		if (cif.miss_get)
			pmem_address = mem_address;
		else
			pmem_address = entry.tag;
	end

	// Write-back data always comes from the entry.
	assign pmem_wdata = entry.data;

	// Entry data is returned only for a real hit.
	a_vic_hit: assert property (@(posedge clk) disable iff (!arst_n)
		cif.ld_from_vic |-> (cif.valid && cif.tag_match))
		else $error("ld_from_vic without a valid tag match, tag=%h addr=%h",
			entry.tag, mem_address);

endmodule : victim_cache_datapath

`default_nettype wire

// ==== victim_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// Three-state controller of the one-entry victim cache.
module victim_cache_control
(
	input  logic    clk,          // Core clock.
	input  logic    arst_n,       // Async reset, active low.
	input  logic    mem_read,     // L1 read without eviction.
	input  logic    d_v_mem_swap, // L1 read with an evicted line.
	input  logic    pmem_resp,    // Memory access done.
	output logic    mem_resp,     // L1 request done.
	output logic    pmem_read,    // Memory line read.
	output logic    pmem_write,   // Memory write-back.
	vc_ctrl_if.ctrl cif           // Datapath commands and status.
);

	vc_types_pkg::vc_state_e state;      // Current state.
	vc_types_pkg::vc_state_e next_state; // Next state.

	logic hit;        // Entry valid and tags equal.
	logic victim_wb;  // Victim must go back to memory.
	logic swap_hit;   // Swap served from the entry.
	logic swap_fill;  // Swap miss, victim can be dropped.
	logic swap_wb;    // Swap miss, victim is dirty.
	logic read_hit;   // Plain read served from the entry.
	logic read_miss;  // Plain read goes to memory.

	// Request decode.
	always_comb
	begin
		hit       = cif.valid & cif.tag_match;
		victim_wb = cif.valid & cif.dirty;
		swap_hit  = d_v_mem_swap & hit;
		swap_fill = d_v_mem_swap & ~hit & ~victim_wb; // Empty or clean victim.
		swap_wb   = d_v_mem_swap & ~hit & victim_wb;
		read_hit  = mem_read & ~d_v_mem_swap & hit;   // Swap wins if both high.
		read_miss = mem_read & ~d_v_mem_swap & ~hit;
	end

	// State actions.
	always_comb
	begin
		cif.ld_cache    = 1'b0;
		cif.ld_from_vic = 1'b0;
		cif.miss_get    = 1'b0;
		pmem_read       = 1'b0;
		pmem_write      = 1'b0;
		mem_resp        = 1'b0;

		case (state)
			vc_types_pkg::idle_check:
			begin
				if (swap_hit)
				begin
					// Lines trade places at this edge.
					cif.ld_from_vic = 1'b1; // Old victim to L1.
					cif.ld_cache    = 1'b1; // Evicted line in.
					mem_resp        = 1'b1; // Zero-wait answer.
				end
				else if (swap_fill)
				begin
					cif.ld_cache = 1'b1; // Overwrite, fetch next.
				end
				else if (read_hit)
				begin
					cif.ld_from_vic = 1'b1; // Entry stays put.
					mem_resp        = 1'b1;
				end
			end

			vc_types_pkg::phys_mem_write:
			begin
				pmem_write = 1'b1; // Tag and data from entry.
				if (pmem_resp)
				begin
					cif.ld_cache = 1'b1; // Old line is safe now.
				end
			end

			vc_types_pkg::phys_mem_read:
			begin
				pmem_read    = 1'b1;
				cif.miss_get = 1'b1; // Address is mem_address.
				mem_resp     = pmem_resp; // Data passes straight through.
			end

			default:
			begin
				// Illegal encoding, outputs stay low.
			end
		endcase
	end

	// Transitions.
	always_comb
	begin
		next_state = state;

		case (state)
			vc_types_pkg::idle_check:
			begin
				if (swap_wb)
					next_state = vc_types_pkg::phys_mem_write;
				else if (swap_fill || read_miss)
					next_state = vc_types_pkg::phys_mem_read;
			end

			vc_types_pkg::phys_mem_write:
			begin
				if (pmem_resp)
					next_state = vc_types_pkg::phys_mem_read; // Fetch follows.
			end

			vc_types_pkg::phys_mem_read:
			begin
				if (pmem_resp)
					next_state = vc_types_pkg::idle_check;
			end

			default:
			begin
				next_state = vc_types_pkg::idle_check; // Recover.
			end
		endcase
	end

	// State register.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= vc_types_pkg::idle_check;
		else
			state <= next_state;
	end

	// One command on the memory port at a time.
	a_pmem_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write both high");

	// Completion only answers a live request.
	a_resp_req: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> (mem_read || d_v_mem_swap))
		else $error("mem_resp without a request");

	// Write-back is always followed by the line fetch.
	a_wb_then_read: assert property (@(posedge clk) disable iff (!arst_n)
		(state == vc_types_pkg::phys_mem_write) |=>
		(state inside {vc_types_pkg::phys_mem_write, vc_types_pkg::phys_mem_read}))
		else $error("phys_mem_write left for %s", state.name());

endmodule : victim_cache_control

`default_nettype wire

// ==== vc_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Control and status between the victim cache FSM and its datapath.
interface vc_ctrl_if #(
	parameter int addr_w = vc_cfg_pkg::ADDR_W, // Line address width.
	parameter int line_w = vc_cfg_pkg::LINE_W  // Line data width.
);

	logic tag_match;   // Entry tag equals mem_address.
	logic valid;       // Entry holds a line.
	logic dirty;       // Entry needs write-back.
	logic ld_cache;    // Load evicted line into entry.
	logic ld_from_vic; // Return entry data to L1.
	logic miss_get;    // Address memory with mem_address.

	// Entry storage is sized by the package widths.
	if (addr_w != vc_cfg_pkg::ADDR_W || line_w != vc_cfg_pkg::LINE_W)
	begin : g_width_check
		$error("vc_ctrl_if: addr_w/line_w differ from vc_cfg_pkg widths");
	end

	modport ctrl (input tag_match, valid, dirty, output ld_cache, ld_from_vic, miss_get);
	modport dpath (output tag_match, valid, dirty, input ld_cache, ld_from_vic, miss_get);

endinterface : vc_ctrl_if

`default_nettype wire

// ==== vc_types_pkg.sv ====
`default_nettype none

// Types for the one-entry victim cache.
package vc_types_pkg;

	// Controller states.
	typedef enum logic [1:0] {
		idle_check,     // Lookup and hit service.
		phys_mem_write, // Dirty victim write-back.
		phys_mem_read   // Line fetch from memory.
	} vc_state_e;

	// The single victim line.
	typedef struct packed {
		logic                          valid; // Entry holds a line.
		logic                          dirty; // Line differs from memory.
		logic [vc_cfg_pkg::ADDR_W-1:0] tag;   // Full line address.
		logic [vc_cfg_pkg::LINE_W-1:0] data;  // Line payload.
	} vc_entry_t;

endpackage : vc_types_pkg

`default_nettype wire

// ==== vc_cfg_pkg.sv ====
`default_nettype none

// Widths shared by the victim cache RTL and its testbench.
package vc_cfg_pkg;

	// Line address, 32-bit byte address with 32-byte lines.
	localparam int ADDR_W = 27; // Tag is the whole line address.

	// One cache line of eight 32-bit words.
	localparam int LINE_W = 256; // Line payload bits.

endpackage : vc_cfg_pkg

`default_nettype wire
